// File: common/mfp_sys_pkg.sv
package mfp_sys_pkg;

    // interrupt controller, EIC mode
    localparam int EIC_CHANNELS = 8;

    typedef logic [2:0]  int_chan_t;
    typedef logic [5:0]  int_vec_t;   // vector number, same as channel index
    typedef logic [16:0] int_off_t;   // byte offset bits 17:1

    localparam logic [17:0] INT_OFF_BASE = 18'h200;   // channel 0
    localparam logic [17:0] INT_OFF_STEP = 18'h020;   // per channel

    // channel positions, higher index wins
    localparam int CH_SW0   = 0;
    localparam int CH_SW1   = 1;
    localparam int CH_UART  = 5;
    localparam int CH_ADC   = 6;
    localparam int CH_TIMER = 7;

    // cycles int_present stays low after an acknowledge
    localparam int INT_HOLDOFF = 3;
    typedef logic [$clog2(INT_HOLDOFF + 1) - 1:0] holdoff_t;

    // clock divider modes
    typedef enum logic [1:0] {
        mode_fast  = 2'd0,
        mode_mid   = 2'd1,
        mode_slow  = 2'd2,
        mode_crawl = 2'd3
    } clk_mode_e;

    // tick period is 2**exp cycles
    localparam int DIV_EXP_FAST  = 1;
    localparam int DIV_EXP_MID   = 3;
    localparam int DIV_EXP_SLOW  = 5;
    localparam int DIV_EXP_CRAWL = 7;

    localparam int DIV_CNT_W = DIV_EXP_CRAWL;   // largest exponent sets the width
    typedef logic [DIV_CNT_W - 1:0] div_cnt_t;

    localparam int MODE_DEBOUNCE = 4;
    typedef logic [$clog2(MODE_DEBOUNCE) - 1:0] deb_cnt_t;

    // reset sequencer
    localparam int RESET_HOLD = 16;
    typedef logic [$clog2(RESET_HOLD) - 1:0] hold_cnt_t;

    typedef enum logic [1:0] {
        rs_cold = 2'd0,
        rs_hold = 2'd1,
        rs_run  = 2'd2
    } rst_state_e;

endpackage

// File: src/mfp_reset_seq.sv
`timescale 1ns/10ps

module mfp_reset_seq (
    input  logic clki,
    input  logic rst_n,
    input  logic rst_cold_pin,
    input  logic rst_soft_pin,
    input  logic memory_load,
    output logic cold_reset,
    output logic soft_reset
);
    logic [1:0]              pin_meta;   // {soft, cold}
    logic [1:0]              pin_sync;
    mfp_sys_pkg::rst_state_e state;
    mfp_sys_pkg::hold_cnt_t  hold_cnt;

    // two-flop synchronizer for both pins
    always_ff @(posedge clki) begin
        if (!rst_n) begin
            pin_meta <= '0;
            pin_sync <= '0;
        end else begin
            pin_meta <= {rst_soft_pin, rst_cold_pin};
            pin_sync <= pin_meta;
        end
    end

    // a cold cause from any state restarts the sequence
    always_ff @(posedge clki) begin
        if (!rst_n || pin_sync[0]) begin
            state    <= mfp_sys_pkg::rs_cold;
            hold_cnt <= '0;
        end else begin
            case (state)
                mfp_sys_pkg::rs_cold: begin
                    state    <= mfp_sys_pkg::rs_hold;
                    hold_cnt <= '0;
                end
                mfp_sys_pkg::rs_hold: begin
                    if (hold_cnt == mfp_sys_pkg::hold_cnt_t'(mfp_sys_pkg::RESET_HOLD - 1)) begin
                        state <= mfp_sys_pkg::rs_run;
                    end else begin
                        hold_cnt <= hold_cnt + 1'b1;
                    end
                end
                mfp_sys_pkg::rs_run: begin
                    state <= mfp_sys_pkg::rs_run;   // stays until a cold cause
                end
                default: begin
                    state <= mfp_sys_pkg::rs_cold;
                end
            endcase
        end
    end

    assign cold_reset = (state != mfp_sys_pkg::rs_run);

    // soft reset also covers a memory load from the programmer
    assign soft_reset = cold_reset | pin_sync[1] | memory_load;

endmodule

// File: src/mfp_clock_div.sv
`timescale 1ns/10ps

module mfp_clock_div (
    input  logic       clki,
    input  logic       rst_n,
    input  logic [1:0] clk_mode,
    output logic       cpu_tick
);
    mfp_sys_pkg::clk_mode_e mode_cand;   // last sampled pin value
    mfp_sys_pkg::clk_mode_e mode_acc;    // debounced mode in use
    mfp_sys_pkg::deb_cnt_t  deb_cnt;
    mfp_sys_pkg::div_cnt_t  div_cnt;
    mfp_sys_pkg::div_cnt_t  tick_mask;
    logic                   accept;

    function automatic mfp_sys_pkg::div_cnt_t mode_mask(mfp_sys_pkg::clk_mode_e m);
        int exp_sel;
        case (m)
            mfp_sys_pkg::mode_fast:  exp_sel = mfp_sys_pkg::DIV_EXP_FAST;
            mfp_sys_pkg::mode_mid:   exp_sel = mfp_sys_pkg::DIV_EXP_MID;
            mfp_sys_pkg::mode_slow:  exp_sel = mfp_sys_pkg::DIV_EXP_SLOW;
            default:                 exp_sel = mfp_sys_pkg::DIV_EXP_CRAWL;
        endcase
        return mfp_sys_pkg::div_cnt_t'((1 << exp_sel) - 1);
    endfunction

    // candidate seen for MODE_DEBOUNCE samples in a row and not yet in use
    assign accept = (mfp_sys_pkg::clk_mode_e'(clk_mode) == mode_cand) &&
                    (mode_cand != mode_acc) &&
                    (deb_cnt == mfp_sys_pkg::deb_cnt_t'(mfp_sys_pkg::MODE_DEBOUNCE - 1));

    always_ff @(posedge clki) begin
        if (!rst_n) begin
            mode_cand <= mfp_sys_pkg::mode_fast;
            mode_acc  <= mfp_sys_pkg::mode_fast;
            deb_cnt   <= '0;
        end else if (mfp_sys_pkg::clk_mode_e'(clk_mode) != mode_cand) begin
            mode_cand <= mfp_sys_pkg::clk_mode_e'(clk_mode);
            deb_cnt   <= mfp_sys_pkg::deb_cnt_t'(1);   // first sample of the new value
        end else if (mode_cand == mode_acc) begin
            deb_cnt <= '0;
        end else if (accept) begin
            mode_acc <= mode_cand;
            deb_cnt  <= '0;
        end else begin
            deb_cnt <= deb_cnt + 1'b1;
        end
    end

    assign tick_mask = mode_mask(mode_acc);

    // free counter, tick when the low exponent bits are all ones
    always_ff @(posedge clki) begin
        if (!rst_n || accept) begin
            div_cnt  <= '0;
            cpu_tick <= 1'b0;
        end else begin
            div_cnt  <= div_cnt + 1'b1;
            cpu_tick <= ((div_cnt & tick_mask) == tick_mask);
        end
    end

endmodule

// File: intc/mfp_int_decode.sv
`timescale 1ns/10ps

module mfp_int_decode (
    input  logic                                   clki,
    input  logic                                   rst_n,
    input  logic [mfp_sys_pkg::EIC_CHANNELS - 1:0] int_src,
    input  logic                                   ack_valid,
    input  mfp_sys_pkg::int_chan_t                 ack_chan,
    output logic [mfp_sys_pkg::EIC_CHANNELS - 1:0] pending
);
    logic [mfp_sys_pkg::EIC_CHANNELS - 1:0] src_q;      // previous levels
    logic [mfp_sys_pkg::EIC_CHANNELS - 1:0] rise;
    logic [mfp_sys_pkg::EIC_CHANNELS - 1:0] clr_mask;

    assign rise = int_src & ~src_q;

    always_comb begin
        clr_mask = '0;
        if (ack_valid) begin
            clr_mask[ack_chan] = 1'b1;
        end
    end

    always_ff @(posedge clki) begin
        if (!rst_n) begin
            src_q   <= '0;
            pending <= '0;
        end else begin
            src_q <= int_src;
            // clear first so a fresh edge in the same cycle survives
            pending <= (pending & ~clr_mask) | rise;
        end
    end

endmodule

// File: intc/mfp_int_arbiter.sv
`timescale 1ns/10ps

module mfp_int_arbiter (
    input  logic                                   clki,
    input  logic                                   rst_n,
    input  logic [mfp_sys_pkg::EIC_CHANNELS - 1:0] pending,
    output logic                                   sel_valid,
    output mfp_sys_pkg::int_chan_t                 sel_chan
);
    mfp_sys_pkg::int_chan_t top_chan;

    // highest index pending, later iterations override
    always_comb begin
        top_chan = '0;
        for (int i = 0; i < mfp_sys_pkg::EIC_CHANNELS; i++) begin
            if (pending[i]) begin
                top_chan = mfp_sys_pkg::int_chan_t'(i);
            end
        end
    end

    always_ff @(posedge clki) begin
        if (!rst_n) begin
            sel_valid <= 1'b0;
        end else begin
            sel_valid <= |pending;
        end
    end

    always_ff @(posedge clki) begin
        sel_chan <= top_chan;
    end

endmodule

// File: intc/mfp_int_result.sv
`timescale 1ns/10ps

module mfp_int_result (
    input  logic                   clki,
    input  logic                   rst_n,
    input  logic                   sel_valid,
    input  mfp_sys_pkg::int_chan_t sel_chan,
    input  logic                   iack,
    output logic                   int_present,
    output mfp_sys_pkg::int_vec_t  int_vector,
    output mfp_sys_pkg::int_off_t  int_offset,
    output logic                   ack_valid,
    output mfp_sys_pkg::int_chan_t ack_chan
);
    mfp_sys_pkg::holdoff_t holdoff;
    logic [17:0]           off_byte;
    logic                  load;

    // byte offset from the EIC vector table
    assign off_byte = mfp_sys_pkg::INT_OFF_BASE + sel_chan * mfp_sys_pkg::INT_OFF_STEP;

    assign load = !int_present && (holdoff == '0) && sel_valid;

    always_ff @(posedge clki) begin
        if (!rst_n) begin
            int_present <= 1'b0;
            ack_valid   <= 1'b0;
            holdoff     <= '0;
        end else begin
            ack_valid <= 1'b0;
            if (int_present) begin
                if (iack) begin
                    int_present <= 1'b0;
                    ack_valid   <= 1'b1;   // clears pending in decode
                    // low for INT_HOLDOFF cycles while the clear reaches the arbiter
                    holdoff <= mfp_sys_pkg::holdoff_t'(mfp_sys_pkg::INT_HOLDOFF - 1);
                end
            end else if (holdoff != '0) begin
                holdoff <= holdoff - 1'b1;
            end else if (sel_valid) begin
                int_present <= 1'b1;
            end
        end
    end

    // vector, offset and channel stay frozen while presented
    always_ff @(posedge clki) begin
        if (load) begin
            int_vector <= mfp_sys_pkg::int_vec_t'(sel_chan);
            int_offset <= off_byte[17:1];
            ack_chan   <= sel_chan;
        end
    end

endmodule

// File: src/mfp_sysctl.sv
`timescale 1ns/10ps

module mfp_sysctl (
    input  logic                  clki,
    input  logic                  rst_n,
    input  logic [1:0]            clk_mode,
    input  logic                  rst_cold_pin,
    input  logic                  rst_soft_pin,
    input  logic                  memory_load,
    input  logic                  timer_int,
    input  logic                  adc_int,
    input  logic                  uart_int,
    input  logic [1:0]            sw_int,
    input  logic                  iack,
    output logic                  cpu_tick,
    output logic                  cold_reset,
    output logic                  soft_reset,
    output logic                  int_present,
    output mfp_sys_pkg::int_vec_t int_vector,
    output mfp_sys_pkg::int_off_t int_offset
);
    logic [mfp_sys_pkg::EIC_CHANNELS - 1:0] int_src;
    logic [mfp_sys_pkg::EIC_CHANNELS - 1:0] pending;
    logic                                   sel_valid;
    mfp_sys_pkg::int_chan_t                 sel_chan;
    logic                                   ack_valid;
    mfp_sys_pkg::int_chan_t                 ack_chan;

    mfp_reset_seq u_reset_seq (
        .clki         ( clki         ),
        .rst_n        ( rst_n        ),
        .rst_cold_pin ( rst_cold_pin ),
        .rst_soft_pin ( rst_soft_pin ),
        .memory_load  ( memory_load  ),
        .cold_reset   ( cold_reset   ),
        .soft_reset   ( soft_reset   )
    );

    mfp_clock_div u_clock_div (
        .clki     ( clki     ),
        .rst_n    ( rst_n    ),
        .clk_mode ( clk_mode ),
        .cpu_tick ( cpu_tick )
    );

    // sources onto EIC channels, 2 to 4 unused
    always_comb begin
        int_src                         = '0;
        int_src[mfp_sys_pkg::CH_SW0]   = sw_int[0];
        int_src[mfp_sys_pkg::CH_SW1]   = sw_int[1];
        int_src[mfp_sys_pkg::CH_UART]  = uart_int;
        int_src[mfp_sys_pkg::CH_ADC]   = adc_int;
        int_src[mfp_sys_pkg::CH_TIMER] = timer_int;
    end

    mfp_int_decode u_int_decode (
        .clki      ( clki      ),
        .rst_n     ( rst_n     ),
        .int_src   ( int_src   ),
        .ack_valid ( ack_valid ),
        .ack_chan  ( ack_chan  ),
        .pending   ( pending   )
    );

    mfp_int_arbiter u_int_arbiter (
        .clki      ( clki      ),
        .rst_n     ( rst_n     ),
        .pending   ( pending   ),
        .sel_valid ( sel_valid ),
        .sel_chan  ( sel_chan  )
    );

    mfp_int_result u_int_result (
        .clki        ( clki        ),
        .rst_n       ( rst_n       ),
        .sel_valid   ( sel_valid   ),
        .sel_chan    ( sel_chan    ),
        .iack        ( iack        ),
        .int_present ( int_present ),
        .int_vector  ( int_vector  ),
        .int_offset  ( int_offset  ),
        .ack_valid   ( ack_valid   ),
        .ack_chan    ( ack_chan    )
    );

endmodule

// File: sim/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// one compare task per DUT result type

task automatic check_vec(
    input string                 name,
    input mfp_sys_pkg::int_vec_t got,
    input mfp_sys_pkg::int_vec_t exp
);
    if (got !== exp) begin
        $display("error: %s got 0x%h expected 0x%h", name, got, exp);
        abort_run();
    end
endtask

task automatic check_off(
    input string                 name,
    input mfp_sys_pkg::int_off_t got,
    input mfp_sys_pkg::int_off_t exp
);
    if (got !== exp) begin
        $display("error: %s got 0x%h expected 0x%h", name, got, exp);
        abort_run();
    end
endtask

// resets, tick and int_present
task automatic check_bit(
    input string name,
    input logic  got,
    input logic  exp
);
    if (got !== exp) begin
        $display("error: %s got 0x%h expected 0x%h", name, got, exp);
        abort_run();
    end
endtask

`endif

// File: sim/tb_sysctl.sv
`timescale 1ns/10ps

module tb_sysctl;

    localparam int CLK_PERIOD   = 20;
    localparam int PRESENT_WAIT = 8;    // cycles allowed for int_present to rise
    localparam int QUIET_CYCLES = 8;
    localparam int PRIO_ROUNDS  = 6;
    localparam int IRQ_SERVE    = PRESENT_WAIT + 2;
    localparam int SYNC_STAGES  = 2;    // reset pin synchronizer depth

    // channels that have a source behind them
    localparam logic [7:0] SRC_MASK = (8'b1 << mfp_sys_pkg::CH_SW0) |
                                      (8'b1 << mfp_sys_pkg::CH_SW1) |
                                      (8'b1 << mfp_sys_pkg::CH_UART) |
                                      (8'b1 << mfp_sys_pkg::CH_ADC) |
                                      (8'b1 << mfp_sys_pkg::CH_TIMER);

    // rough upper bound on each test's length in cycles
    localparam int RESET_CYCLES = 5 + 2 * (mfp_sys_pkg::RESET_HOLD + 6) + 20;
    localparam int TICK_CYCLES  = 5 * (mfp_sys_pkg::MODE_DEBOUNCE + 6) + 6 +
                                  3 * ((1 << mfp_sys_pkg::DIV_EXP_FAST) +
                                       (1 << mfp_sys_pkg::DIV_EXP_MID) +
                                       (1 << mfp_sys_pkg::DIV_EXP_SLOW) +
                                       (1 << mfp_sys_pkg::DIV_EXP_CRAWL));
    localparam int IRQ_CYCLES   = 5 * (IRQ_SERVE + QUIET_CYCLES + 1) +
                                  PRIO_ROUNDS * (5 * IRQ_SERVE + QUIET_CYCLES + 1) +
                                  3 * IRQ_SERVE + 16 + QUIET_CYCLES;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + TICK_CYCLES + IRQ_CYCLES) *
                                  CLK_PERIOD * 3 / 2;

    logic                  clki;
    logic                  rst_n;
    logic [1:0]            clk_mode;
    logic                  rst_cold_pin;
    logic                  rst_soft_pin;
    logic                  memory_load;
    logic                  timer_int;
    logic                  adc_int;
    logic                  uart_int;
    logic [1:0]            sw_int;
    logic                  iack;
    logic                  cpu_tick;
    logic                  cold_reset;
    logic                  soft_reset;
    logic                  int_present;
    mfp_sys_pkg::int_vec_t int_vector;
    mfp_sys_pkg::int_off_t int_offset;
    integer                seed;

    mfp_sysctl dut (
        .clki         ( clki         ),
        .rst_n        ( rst_n        ),
        .clk_mode     ( clk_mode     ),
        .rst_cold_pin ( rst_cold_pin ),
        .rst_soft_pin ( rst_soft_pin ),
        .memory_load  ( memory_load  ),
        .timer_int    ( timer_int    ),
        .adc_int      ( adc_int      ),
        .uart_int     ( uart_int     ),
        .sw_int       ( sw_int       ),
        .iack         ( iack         ),
        .cpu_tick     ( cpu_tick     ),
        .cold_reset   ( cold_reset   ),
        .soft_reset   ( soft_reset   ),
        .int_present  ( int_present  ),
        .int_vector   ( int_vector   ),
        .int_offset   ( int_offset   )
    );

    initial begin
        clki = 1'b0;
        forever #(CLK_PERIOD / 2) clki = ~clki;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        abort_run();
    end

    task automatic abort_run;
        $display("Result: FAILED");
        $fatal(1, "simulation stopped");
    endtask

    `include "tb_checks.svh"

    // walks the EIC table one step per channel
    function automatic mfp_sys_pkg::int_off_t expected_offset(input int ch);
        int byte_off;
        byte_off = mfp_sys_pkg::INT_OFF_BASE;   // channel 0 entry
        repeat (ch) begin
            byte_off += mfp_sys_pkg::INT_OFF_STEP;
        end
        return mfp_sys_pkg::int_off_t'(byte_off >> 1);   // bits 17:1
    endfunction

    task automatic set_sources(input logic [7:0] mask);
        sw_int    = {mask[mfp_sys_pkg::CH_SW1], mask[mfp_sys_pkg::CH_SW0]};
        uart_int  = mask[mfp_sys_pkg::CH_UART];
        adc_int   = mask[mfp_sys_pkg::CH_ADC];
        timer_int = mask[mfp_sys_pkg::CH_TIMER];
    endtask

    // one-cycle pulse on the chosen sources
    task automatic raise_sources(input logic [7:0] mask);
        set_sources(mask);
        @(negedge clki);
        set_sources(8'h00);
    endtask

    // high for exactly hold_cycles, low on the cycle after
    task automatic expect_cold_release(input int hold_cycles);
        repeat (hold_cycles) begin
            @(negedge clki);
            check_bit("cold_reset", cold_reset, 1'b1);
        end
        @(negedge clki);
        check_bit("cold_reset", cold_reset, 1'b0);
    endtask

    task automatic wait_present;
        for (int n = 0; n < PRESENT_WAIT && !int_present; n++) @(negedge clki);
        if (!int_present) begin
            $display("int_present did not rise within %0d cycles", PRESENT_WAIT);
            abort_run();
        end
    endtask

    task automatic pulse_iack;
        iack = 1'b1;
        @(negedge clki);
        iack = 1'b0;
        check_bit("int_present", int_present, 1'b0);   // low right after the ack
    endtask

    task automatic serve(input int ch);
        wait_present();
        check_vec("int_vector", int_vector, mfp_sys_pkg::int_vec_t'(ch));
        check_off("int_offset", int_offset, expected_offset(ch));
        pulse_iack();
    endtask

    task automatic expect_quiet;
        repeat (QUIET_CYCLES) begin
            @(negedge clki);
            check_bit("int_present", int_present, 1'b0);
        end
    endtask

    task automatic test_reset_release;
        expect_cold_release(mfp_sys_pkg::RESET_HOLD);
        check_bit("soft_reset", soft_reset, 1'b0);
        // cold pin pulse restarts the sequence
        rst_cold_pin = 1'b1;
        repeat (4) @(negedge clki);
        check_bit("cold_reset", cold_reset, 1'b1);
        check_bit("soft_reset", soft_reset, 1'b1);
        rst_cold_pin = 1'b0;
        expect_cold_release(mfp_sys_pkg::RESET_HOLD + SYNC_STAGES);
        rst_soft_pin = 1'b1;
        repeat (3) @(negedge clki);
        check_bit("soft_reset", soft_reset, 1'b1);
        check_bit("cold_reset", cold_reset, 1'b0);
        rst_soft_pin = 1'b0;
        repeat (3) @(negedge clki);
        check_bit("soft_reset", soft_reset, 1'b0);
        memory_load = 1'b1;   // not synchronized
        @(negedge clki);
        check_bit("soft_reset", soft_reset, 1'b1);
        check_bit("cold_reset", cold_reset, 1'b0);
        memory_load = 1'b0;
        @(negedge clki);
        check_bit("soft_reset", soft_reset, 1'b0);
    endtask

    task automatic check_tick_mode(input logic [1:0] mode, input int exp_val);
        int period;
        period   = 1 << exp_val;
        clk_mode = mode;
        repeat (mfp_sys_pkg::MODE_DEBOUNCE + 4) @(negedge clki);
        for (int n = 0; n < period + 2 && !cpu_tick; n++) @(negedge clki);
        if (!cpu_tick) begin
            $display("cpu_tick never pulsed in mode %0d", mode);
            abort_run();
        end
        // pulse only on the boundary of each of two periods
        for (int k = 1; k <= 2 * period; k++) begin
            @(negedge clki);
            check_bit("cpu_tick", cpu_tick, (k % period) == 0);
        end
    endtask

    task automatic test_tick_modes;
        check_tick_mode(mfp_sys_pkg::mode_fast, mfp_sys_pkg::DIV_EXP_FAST);
        check_tick_mode(mfp_sys_pkg::mode_mid, mfp_sys_pkg::DIV_EXP_MID);
        check_tick_mode(mfp_sys_pkg::mode_slow, mfp_sys_pkg::DIV_EXP_SLOW);
        check_tick_mode(mfp_sys_pkg::mode_crawl, mfp_sys_pkg::DIV_EXP_CRAWL);
        check_tick_mode(mfp_sys_pkg::mode_fast, mfp_sys_pkg::DIV_EXP_FAST);
    endtask

    task automatic test_single_irq;
        int chans[5];
        chans = '{mfp_sys_pkg::CH_SW0, mfp_sys_pkg::CH_SW1, mfp_sys_pkg::CH_UART,
                  mfp_sys_pkg::CH_ADC, mfp_sys_pkg::CH_TIMER};
        foreach (chans[i]) begin
            raise_sources(8'b1 << chans[i]);
            serve(chans[i]);
            expect_quiet();   // same event must not come back
        end
    endtask

    task automatic test_priority;
        logic [7:0] mask;
        repeat (PRIO_ROUNDS) begin
            mask = 8'($random(seed)) & SRC_MASK;
            if (mask == 8'h00) begin
                mask = 8'b1 << mfp_sys_pkg::CH_TIMER;
            end
            raise_sources(mask);
            for (int ch = 7; ch >= 0; ch--) begin
                if (mask[ch]) begin
                    serve(ch);
                end
            end
            expect_quiet();
        end
    endtask

    task automatic test_back_pressure;
        raise_sources(8'b1 << mfp_sys_pkg::CH_UART);
        wait_present();
        raise_sources(8'b1 << mfp_sys_pkg::CH_TIMER);
        raise_sources(8'b1 << mfp_sys_pkg::CH_ADC);
        @(negedge clki);
        raise_sources(8'b1 << mfp_sys_pkg::CH_ADC);   // second edge merges
        repeat (10) begin
            @(negedge clki);
            check_bit("int_present", int_present, 1'b1);
            check_vec("int_vector", int_vector, mfp_sys_pkg::int_vec_t'(mfp_sys_pkg::CH_UART));
            check_off("int_offset", int_offset, expected_offset(mfp_sys_pkg::CH_UART));
        end
        pulse_iack();
        serve(mfp_sys_pkg::CH_TIMER);
        serve(mfp_sys_pkg::CH_ADC);
        expect_quiet();
    endtask

    initial begin
        seed         = 89;
        rst_n        = 1'b0;
        clk_mode     = mfp_sys_pkg::mode_fast;
        rst_cold_pin = 1'b0;
        rst_soft_pin = 1'b0;
        memory_load  = 1'b0;
        iack         = 1'b0;
        set_sources(8'h00);
        repeat (5) @(negedge clki);
        check_bit("cold_reset", cold_reset, 1'b1);
        check_bit("soft_reset", soft_reset, 1'b1);
        check_bit("int_present", int_present, 1'b0);
        check_bit("cpu_tick", cpu_tick, 1'b0);
        rst_n = 1'b1;
        test_reset_release();
        test_tick_modes();
        test_single_irq();
        test_priority();
        test_back_pressure();
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: build.f
+incdir+sim
common/mfp_sys_pkg.sv
src/mfp_reset_seq.sv
src/mfp_clock_div.sv
intc/mfp_int_decode.sv
intc/mfp_int_arbiter.sv
intc/mfp_int_result.sv
src/mfp_sysctl.sv
sim/tb_sysctl.sv
